// File: compile.f
common/elem_cfg_pkg.sv
common/elem_wb_pkg.sv
elem_wb/elem_vd_counter.sv
elem_wb/elem_flush_ctrl.sv
elem_wb/elem_result_pack.sv
elem_wb/elem_wb_top.sv
testbench/tb_clk_gen.sv
testbench/tb_elem_wb.sv

// File: testbench/tb_elem_wb.sv
// ==================================================
// Testbench for the element write-back stage
// ==================================================

`timescale 1ns/1ps

module tb_elem_wb import elem_cfg_pkg::*, elem_wb_pkg::*; ();

        localparam int TEST_CYCLES = 4 + 36 + 20 + 24 + 12 + 72;
        localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

        logic clk_i, async_rst_ni;
        logic unit_valid_i, unit_ready_o, unit_xreg_valid_i;
        elem_ctrl_t unit_ctrl_i;
        elem_res_t unit_res_i;
        vaddr_t unit_xreg_addr_i;
        logic pipe_out_valid_o, pipe_out_ready_i, pend_clear_o, instr_done_o;
        vreg_wr_t vreg_wr_o;
        emul_e pend_clear_cnt_o;
        logic xreg_valid_o, xreg_ready_i;
        instr_id_t xreg_id_o;
        vaddr_t xreg_addr_o;
        elem_data_t xreg_data_o;
        logic [ID_CNT-1:0] instr_spec_i, instr_killed_i;

        integer seed = 32'h646;
        int test_no, err_cnt, fail_tests, cyc_cnt, esize, ref_bytes, flush_left;
        string test_name;
        vsew_e cur_eew;
        emul_e cur_emul;
        vaddr_t cur_vaddr;
        logic bp_en, bp_ready, ref_clr, last_acc, accept, vec_acc, exp_store, exp_shift;
        vaddr_t exp_vaddr;

        tb_clk_gen i_tb_clk_gen (.clk_o(clk_i), .rst_no(async_rst_ni));

        elem_wb_top i_elem_wb_top (.*);

        assign pipe_out_ready_i = bp_en ? bp_ready : 1'b1;
        assign accept = unit_valid_i & unit_ready_o;

        // Reference byte counter of the destination group
        always_comb begin
                esize     = 1 << int'(cur_eew);
                exp_store = ((ref_bytes + esize) % VREG_BYTES) == 0;
                exp_shift = (ref_bytes % RES_BYTES) == 0;
                exp_vaddr = cur_vaddr |
                            vaddr_t'(((ref_bytes + esize - 1) / VREG_BYTES) & ((1 << cur_emul) - 1));
                vec_acc   = accept && test_no inside {2, 3, 4, 6} && flush_left == 0 &&
                            !unit_ctrl_i.xreg;
        end

        always @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        last_acc   <= 1'b0;
                        ref_bytes  <= 0;
                        flush_left <= 0;
                end else begin
                        last_acc <= accept;
                        if (ref_clr) begin
                                ref_bytes <= 0;
                        end else if (accept && unit_res_i.res_valid && !unit_ctrl_i.xreg) begin
                                ref_bytes <= ref_bytes + esize;
                        end
                        if (accept && unit_ctrl_i.last_cycle && unit_ctrl_i.requires_flush) begin
                                flush_left <= (VREG_BYTES - ((ref_bytes + esize) % VREG_BYTES)) /
                                              esize;
                        end else if (flush_left != 0 && pipe_out_ready_i) begin
                                flush_left <= flush_left - 1;
                        end
                end
        end

        always @(posedge clk_i) begin
                cyc_cnt <= cyc_cnt + 1;
                if (cyc_cnt >= CYCLE_LIMIT) begin
                        $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        always @(negedge clk_i) begin
                bp_ready = $random(seed) & 1;
        end

        task automatic report_mismatch(input string what, input int exp_v, input int act_v);
                $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp_v, act_v);
                err_cnt++;
        endtask

        task automatic report_error(input string msg);
                $display("error in %s: %s", test_name, msg);
                err_cnt++;
        endtask

        assert property (@(posedge clk_i) disable iff (!async_rst_ni) test_no == 1 |->
                !(pipe_out_valid_o | xreg_valid_o | instr_done_o | pend_clear_o))
                else report_error("output active while idle after reset");
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                vec_acc |-> vreg_wr_o.store == exp_store)
                else report_mismatch("store", $sampled(exp_store), $sampled(vreg_wr_o.store));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                vec_acc |-> vreg_wr_o.shift == exp_shift)
                else report_mismatch("shift", $sampled(exp_shift), $sampled(vreg_wr_o.shift));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                vec_acc |-> vreg_wr_o.vaddr == exp_vaddr)
                else report_mismatch("vaddr", $sampled(exp_vaddr), $sampled(vreg_wr_o.vaddr));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                vec_acc |-> vreg_wr_o.data == unit_res_i.data)
                else report_mismatch("data", $sampled(unit_res_i.data),
                                     $sampled(vreg_wr_o.data));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                pend_clear_o |-> pend_clear_cnt_o == cur_emul)
                else report_mismatch("clear count", $sampled(cur_emul),
                                     $sampled(pend_clear_cnt_o));

        // Flush cycles emit masked results until the register is full
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                flush_left != 0 |-> pipe_out_valid_o && !unit_ready_o && vreg_wr_o.mask == '0)
                else report_error("flush cycle without valid masked result or with unit ready");
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                flush_left != 0 |-> vreg_wr_o.store == (flush_left == 1))
                else report_mismatch("flush store", $sampled(flush_left == 1),
                                     $sampled(vreg_wr_o.store));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                flush_left != 0 |-> instr_done_o == (flush_left == 1) &&
                pend_clear_o == (flush_left == 1))
                else report_mismatch("done", $sampled(flush_left == 1), $sampled(instr_done_o));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                test_no == 4 && flush_left == 0 && !unit_valid_i |-> !pipe_out_valid_o)
                else report_error("flush ran longer than the register fill");

        // Xreg port gating
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                unit_valid_i && unit_xreg_valid_i && instr_spec_i[unit_ctrl_i.id] |->
                !xreg_valid_o && !pipe_out_valid_o && !unit_ready_o)
                else report_error("speculative xreg result was not stalled");
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                test_no == 5 && unit_valid_i && unit_xreg_valid_i && xreg_ready_i &&
                !instr_spec_i[unit_ctrl_i.id] && !instr_killed_i[unit_ctrl_i.id] |->
                xreg_valid_o && xreg_id_o == unit_ctrl_i.id)
                else report_mismatch("xreg id", $sampled(unit_ctrl_i.id), $sampled(xreg_id_o));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                unit_valid_i && instr_killed_i[unit_ctrl_i.id] |-> !xreg_valid_o)
                else report_error("xreg write raised for a killed instruction");
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                xreg_valid_o |-> xreg_addr_o == unit_xreg_addr_i)
                else report_mismatch("xreg addr", $sampled(unit_xreg_addr_i),
                                     $sampled(xreg_addr_o));
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                xreg_valid_o |-> xreg_data_o == unit_res_i.data)
                else report_mismatch("xreg data", $sampled(unit_res_i.data),
                                     $sampled(xreg_data_o));

        task automatic start_test(input int no, input string name, input vsew_e eew,
                                  input emul_e emul, input vaddr_t va);
                test_no   = no;
                test_name = name;
                cur_eew   = eew;
                cur_emul  = emul;
                cur_vaddr = va;
                ref_clr   = 1'b1;
                @(negedge clk_i);
                ref_clr   = 1'b0;
        endtask

        task automatic end_test(input int err_start);
                unit_valid_i = 1'b0;
                repeat (2) @(negedge clk_i);
                if (err_cnt == err_start) begin
                        $display("%s: ok", test_name);
                end else begin
                        $display("%s: %0d errors", test_name, err_cnt - err_start);
                        fail_tests++;
                end
        endtask

        // Offers one unit item and waits until it is accepted
        task automatic send(input logic first, input logic last, input logic flush,
                            input logic xr, input instr_id_t id);
                unit_valid_i                = 1'b1;
                unit_ctrl_i.id              = id;
                unit_ctrl_i.eew             = cur_eew;
                unit_ctrl_i.emul            = cur_emul;
                unit_ctrl_i.res_vaddr       = cur_vaddr;
                unit_ctrl_i.first_cycle     = first;
                unit_ctrl_i.last_cycle      = last;
                unit_ctrl_i.requires_flush  = flush;
                unit_ctrl_i.xreg            = xr;
                unit_xreg_valid_i           = xr;
                unit_res_i.res_valid        = ~xr;
                unit_res_i.data             = $random(seed);
                unit_res_i.mask             = 4'hf;
                @(negedge clk_i);
                while (!last_acc) @(negedge clk_i);
        endtask

        task automatic send_burst(input int n);
                for (int i = 0; i < n; i++) begin
                        send(i == 0, i == n - 1, 1'b0, 1'b0, 3'd1);
                end
        endtask

        initial begin
                int err_start;
                unit_valid_i = 1'b0;
                unit_ctrl_i = '0;
                unit_res_i = '0;
                unit_xreg_valid_i = 1'b0;
                unit_xreg_addr_i = 5'd7;
                xreg_ready_i = 1'b0;
                instr_spec_i = '0;
                instr_killed_i = '0;
                bp_en = 1'b0;
                ref_clr = 1'b0;
                err_cnt = 0;
                fail_tests = 0;
                cyc_cnt = 0;
                test_no = 0;
                cur_eew = VSEW_8;
                cur_emul = EMUL_1;
                cur_vaddr = '0;
                wait (async_rst_ni);

                err_start = err_cnt;
                start_test(1, "reset", VSEW_8, EMUL_1, 5'd0);
                repeat (3) @(negedge clk_i);
                end_test(err_start);

                err_start = err_cnt;
                start_test(2, "register fill", VSEW_8, EMUL_1, 5'd3);
                send_burst(32);
                end_test(err_start);

                err_start = err_cnt;
                start_test(3, "grouping", VSEW_16, EMUL_2, 5'd8);
                send_burst(16);
                end_test(err_start);

                err_start = err_cnt;
                start_test(4, "flush", VSEW_8, EMUL_1, 5'd4);
                for (int i = 0; i < 5; i++) begin
                        send(i == 0, i == 4, i == 4, 1'b0, 3'd2);
                end
                unit_valid_i = 1'b0;
                while (flush_left != 0) @(negedge clk_i);
                end_test(err_start);

                err_start = err_cnt;
                start_test(5, "xreg port", VSEW_32, EMUL_1, 5'd0);
                xreg_ready_i = 1'b1;
                instr_spec_i[3] = 1'b1;
                unit_valid_i = 1'b1;
                unit_ctrl_i.id = 3'd3;
                unit_xreg_valid_i = 1'b1;
                repeat (3) @(negedge clk_i);
                instr_spec_i[3] = 1'b0;
                send(1'b1, 1'b1, 1'b0, 1'b1, 3'd3);
                instr_killed_i[5] = 1'b1;
                xreg_ready_i = 1'b0;
                send(1'b1, 1'b1, 1'b0, 1'b1, 3'd5);
                unit_xreg_valid_i = 1'b0;
                instr_killed_i = '0;
                end_test(err_start);

                err_start = err_cnt;
                start_test(6, "back-pressure", VSEW_8, EMUL_1, 5'd6);
                bp_en = 1'b1;
                send_burst(32);
                bp_en = 1'b0;
                end_test(err_start);

                $display("tests run 6, tests failed %0d, checks failed %0d", fail_tests, err_cnt);
                if (err_cnt == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

// File: testbench/tb_clk_gen.sv
// ==================================================
// Testbench clock and reset generator
// ==================================================

`timescale 1ns/1ps

module tb_clk_gen (
        output logic clk_o,
        output logic rst_no
);

        localparam time HALF_PERIOD = 10ns;

        initial begin
                clk_o = 1'b0;
                forever #(HALF_PERIOD) clk_o = ~clk_o;
        end

        // Reset held low for two clock cycles
        initial begin
                rst_no = 1'b0;
                repeat (2) @(posedge clk_o);
                @(negedge clk_o);
                rst_no = 1'b1;
        end

endmodule

// File: elem_wb/elem_wb_top.sv
// ================================================
// Element unit result write-back stage
// ================================================

`timescale 1ns/1ps

module elem_wb_top import elem_cfg_pkg::*, elem_wb_pkg::*; (
        input  logic              clk_i,
        input  logic              async_rst_ni,

        input  logic              unit_valid_i,
        output logic              unit_ready_o,
        input  elem_ctrl_t        unit_ctrl_i,
        input  elem_res_t         unit_res_i,
        input  logic              unit_xreg_valid_i,
        input  vaddr_t            unit_xreg_addr_i,

        output logic              pipe_out_valid_o,
        input  logic              pipe_out_ready_i,
        output vreg_wr_t          vreg_wr_o,
        output logic              pend_clear_o,
        output emul_e             pend_clear_cnt_o,
        output logic              instr_done_o,

        output logic              xreg_valid_o,
        input  logic              xreg_ready_i,
        output instr_id_t         xreg_id_o,
        output vaddr_t            xreg_addr_o,
        output elem_data_t        xreg_data_o,

        input  logic [ID_CNT-1:0] instr_spec_i,
        input  logic [ID_CNT-1:0] instr_killed_i
);

        logic         advance;
        logic         res_valid;
        vd_count_t    count_next;
        logic         count_full;
        flush_state_t flush_state;
        logic         flush_end;

        elem_vd_counter i_elem_vd_counter (
                .clk_i         ( clk_i                                 ),
                .async_rst_ni  ( async_rst_ni                          ),
                .advance_i     ( advance                               ),
                .res_valid_i   ( res_valid                             ),
                .first_cycle_i ( unit_valid_i & unit_ctrl_i.first_cycle ),
                .eew_i         ( unit_ctrl_i.eew                       ),
                .flush_state_i ( flush_state                           ),
                .count_next_o  ( count_next                            ),
                .count_full_o  ( count_full                            )
        );

        elem_flush_ctrl i_elem_flush_ctrl (
                .clk_i         ( clk_i        ),
                .async_rst_ni  ( async_rst_ni ),
                .advance_i     ( advance      ),
                .unit_valid_i  ( unit_valid_i ),
                .unit_ctrl_i   ( unit_ctrl_i  ),
                .count_full_i  ( count_full   ),
                .flush_state_o ( flush_state  ),
                .flush_end_o   ( flush_end    )
        );

        elem_result_pack i_elem_result_pack (
                .unit_valid_i      ( unit_valid_i      ),
                .unit_ready_o      ( unit_ready_o      ),
                .unit_ctrl_i       ( unit_ctrl_i       ),
                .unit_res_i        ( unit_res_i        ),
                .unit_xreg_valid_i ( unit_xreg_valid_i ),
                .unit_xreg_addr_i  ( unit_xreg_addr_i  ),
                .pipe_out_valid_o  ( pipe_out_valid_o  ),
                .pipe_out_ready_i  ( pipe_out_ready_i  ),
                .vreg_wr_o         ( vreg_wr_o         ),
                .res_valid_o       ( res_valid         ),
                .advance_o         ( advance           ),
                .count_next_i      ( count_next        ),
                .count_full_i      ( count_full        ),
                .flush_state_i     ( flush_state       ),
                .flush_end_i       ( flush_end         ),
                .pend_clear_o      ( pend_clear_o      ),
                .pend_clear_cnt_o  ( pend_clear_cnt_o  ),
                .instr_done_o      ( instr_done_o      ),
                .xreg_valid_o      ( xreg_valid_o      ),
                .xreg_ready_i      ( xreg_ready_i      ),
                .xreg_id_o         ( xreg_id_o         ),
                .xreg_addr_o       ( xreg_addr_o       ),
                .xreg_data_o       ( xreg_data_o       ),
                .instr_spec_i      ( instr_spec_i      ),
                .instr_killed_i    ( instr_killed_i    )
        );

endmodule

// File: elem_wb/elem_result_pack.sv
// ================================================
// Result packer: vector register write, xreg port,
// handshakes and done/clear pulses
// ================================================

`timescale 1ns/1ps

module elem_result_pack import elem_cfg_pkg::*, elem_wb_pkg::*; (
        input  logic              unit_valid_i,
        output logic              unit_ready_o,
        input  elem_ctrl_t        unit_ctrl_i,
        input  elem_res_t         unit_res_i,
        input  logic              unit_xreg_valid_i,
        input  vaddr_t            unit_xreg_addr_i,

        output logic              pipe_out_valid_o,
        input  logic              pipe_out_ready_i,
        output vreg_wr_t          vreg_wr_o,

        output logic              res_valid_o,
        output logic              advance_o,
        input  vd_count_t         count_next_i,
        input  logic              count_full_i,
        input  flush_state_t      flush_state_i,
        input  logic              flush_end_i,

        output logic              pend_clear_o,
        output emul_e             pend_clear_cnt_o,
        output logic              instr_done_o,

        output logic              xreg_valid_o,
        input  logic              xreg_ready_i,
        output instr_id_t         xreg_id_o,
        output vaddr_t            xreg_addr_o,
        output elem_data_t        xreg_data_o,

        input  logic [ID_CNT-1:0] instr_spec_i,
        input  logic [ID_CNT-1:0] instr_killed_i
);

        logic                 flushing;
        logic                 spec;
        logic                 killed;
        logic                 stall;
        logic                 unit_out;
        vsew_e                eew;
        emul_e                emul;
        vaddr_t               base_vaddr;
        logic [CNT_MUL_W-1:0] mul_idx;
        logic [RES_OFF_W-1:0] res_off;

        assign flushing = flush_state_i.active;
        assign spec     = instr_spec_i[unit_ctrl_i.id];
        assign killed   = instr_killed_i[unit_ctrl_i.id];

        // Hold an xreg result until it is non-speculative and the port can take it
        assign stall = unit_valid_i & unit_xreg_valid_i & ~flushing &
                       (spec | (~xreg_ready_i & ~killed));

        assign unit_out         = unit_valid_i & ~stall & ~flushing;
        assign res_valid_o      = unit_valid_i & unit_res_i.res_valid;
        assign advance_o        = pipe_out_ready_i & ~stall;
        assign pipe_out_valid_o = (unit_valid_i & ~stall) | flushing;
        assign unit_ready_o     = pipe_out_ready_i & ~flushing & ~stall;

        assign xreg_valid_o = unit_valid_i & unit_xreg_valid_i & ~spec & ~killed & ~flushing;
        assign xreg_id_o    = unit_ctrl_i.id;
        assign xreg_addr_o  = unit_xreg_addr_i;
        assign xreg_data_o  = unit_res_i.data;

        assign eew        = flushing ? flush_state_i.eew   : unit_ctrl_i.eew;
        assign emul       = flushing ? flush_state_i.emul  : unit_ctrl_i.emul;
        assign base_vaddr = flushing ? flush_state_i.vaddr : unit_ctrl_i.res_vaddr;
        assign mul_idx    = count_next_i[CNT_LOW_W +: CNT_MUL_W];
        assign res_off    = count_next_i[RES_OFF_W-1:0];

        always_comb begin
                vreg_wr_o.instr_id = flushing ? flush_state_i.id : unit_ctrl_i.id;
                vreg_wr_o.eew      = eew;

                // Register within the group comes from the count
                unique case (emul)
                        EMUL_2:  vreg_wr_o.vaddr = base_vaddr | vaddr_t'(mul_idx[0]);
                        EMUL_4:  vreg_wr_o.vaddr = base_vaddr | vaddr_t'(mul_idx[1:0]);
                        EMUL_8:  vreg_wr_o.vaddr = base_vaddr | vaddr_t'(mul_idx);
                        default: vreg_wr_o.vaddr = base_vaddr;
                endcase

                // New result word starts at the first element of each word
                unique case (eew)
                        VSEW_16: vreg_wr_o.shift = (res_off[RES_OFF_W-1:1] == '0);
                        VSEW_32: vreg_wr_o.shift = (res_off[RES_OFF_W-1:2] == '0);
                        default: vreg_wr_o.shift = (res_off == '0);
                endcase

                vreg_wr_o.store    = ((~unit_ctrl_i.xreg & unit_res_i.res_valid) | flushing) &
                                     count_full_i;
                vreg_wr_o.valid    = flushing | unit_res_i.res_valid;
                vreg_wr_o.elemwise = 1'b1;
                vreg_wr_o.data     = unit_res_i.data;
                vreg_wr_o.mask     = flushing ? '0 : unit_res_i.mask;
        end

        assign instr_done_o = (unit_out & unit_ctrl_i.last_cycle & ~unit_ctrl_i.requires_flush) |
                              flush_end_i;
        assign pend_clear_o = (unit_out & unit_ctrl_i.last_cycle & ~unit_ctrl_i.requires_flush &
                               ~unit_ctrl_i.xreg) | flush_end_i;
        // Pending reads are released for the whole destination group
        assign pend_clear_cnt_o = emul;

endmodule

// File: elem_wb/elem_flush_ctrl.sv
// ================================================
// Flush controller: holds a flushing instruction
// until its destination register is full
// ================================================

`timescale 1ns/1ps

module elem_flush_ctrl import elem_cfg_pkg::*, elem_wb_pkg::*; (
        input  logic         clk_i,
        input  logic         async_rst_ni,
        input  logic         advance_i,
        input  logic         unit_valid_i,
        input  elem_ctrl_t   unit_ctrl_i,
        input  logic         count_full_i,
        output flush_state_t flush_state_o,
        output logic         flush_end_o
);

        typedef enum logic {
                IDLE,
                FLUSH
        } state_e;

        state_e    state_q, state_d;
        instr_id_t id_q;
        vsew_e     eew_q;
        emul_e     emul_q;
        vaddr_t    vaddr_q;
        logic      start;

        // Accepted last cycle of an instruction that leaves its register partly written
        assign start = unit_valid_i & unit_ctrl_i.last_cycle & unit_ctrl_i.requires_flush;

        always_comb begin
                state_d     = state_q;
                flush_end_o = 1'b0;
                unique case (state_q)
                        IDLE: begin
                                if (start) begin
                                        state_d = FLUSH;
                                end
                        end
                        FLUSH: begin
                                if (count_full_i) begin
                                        state_d     = IDLE;
                                        flush_end_o = 1'b1;
                                end
                        end
                        default: state_d = IDLE;
                endcase
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        state_q <= IDLE;
                end else if (advance_i) begin
                        state_q <= state_d;
                end
        end

        always_ff @(posedge clk_i) begin
                if (advance_i && state_q == IDLE && start) begin
                        id_q    <= unit_ctrl_i.id;
                        eew_q   <= unit_ctrl_i.eew;
                        emul_q  <= unit_ctrl_i.emul;
                        vaddr_q <= unit_ctrl_i.res_vaddr;
                end
        end

        always_comb begin
                flush_state_o.active = (state_q == FLUSH);
                flush_state_o.id     = id_q;
                flush_state_o.eew    = eew_q;
                flush_state_o.emul   = emul_q;
                flush_state_o.vaddr  = vaddr_q;
        end

        // A flush only starts while the destination register is still partly written
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                (state_q == IDLE && advance_i && start) |-> !count_full_i);

endmodule

// File: elem_wb/elem_vd_counter.sv
// ================================================
// Destination register group byte counter
// ================================================

`timescale 1ns/1ps

module elem_vd_counter import elem_cfg_pkg::*, elem_wb_pkg::*; (
        input  logic         clk_i,
        input  logic         async_rst_ni,
        input  logic         advance_i,
        input  logic         res_valid_i,
        input  logic         first_cycle_i,
        input  vsew_e        eew_i,
        input  flush_state_t flush_state_i,
        output vd_count_t    count_next_o,
        output logic         count_full_o
);

        vd_count_t count_q;
        logic      has_valid_q, has_valid_d;
        logic      first_valid;
        logic      step;
        vsew_e     cur_eew;
        logic [1:0] elem_off;

        always_comb begin
                has_valid_d = has_valid_q;
                if (first_cycle_i) begin
                        has_valid_d = 1'b0;
                end
                if (res_valid_i) begin
                        has_valid_d = 1'b1;
                end
        end

        assign first_valid = ~flush_state_i.active & res_valid_i &
                             (first_cycle_i | ~has_valid_q);
        assign step        = flush_state_i.active | res_valid_i;
        assign cur_eew     = flush_state_i.active ? flush_state_i.eew : eew_i;

        // Offset of the last byte of one element
        always_comb begin
                unique case (cur_eew)
                        VSEW_16: elem_off = 2'd1;
                        VSEW_32: elem_off = 2'd3;
                        default: elem_off = 2'd0;
                endcase
        end

        always_comb begin
                count_next_o = count_q;
                if (first_valid) begin
                        count_next_o = vd_count_t'(elem_off);
                end else if (step) begin
                        count_next_o = count_q + vd_count_t'(elem_off) + vd_count_t'(1);
                end
        end

        assign count_full_o = (count_next_o[CNT_LOW_W-1:0] == '1);

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        count_q     <= '0;
                        has_valid_q <= 1'b0;
                end else if (advance_i) begin
                        count_q     <= count_next_o;
                        has_valid_q <= has_valid_d;
                end
        end

        // Count always points at the last byte of a whole element
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                (advance_i && step) |=>
                ((count_q[1:0] & $past(elem_off)) == $past(elem_off)));

endmodule

// File: common/elem_wb_pkg.sv
// ================================================
// Element write-back structs: unit control, unit
// result, flush state and vector register write
// ================================================

package elem_wb_pkg;

        import elem_cfg_pkg::*;

        // Control word delivered with each element unit result
        typedef struct packed {
                instr_id_t id;
                vsew_e     eew;
                emul_e     emul;
                vaddr_t    res_vaddr;
                logic      first_cycle;
                logic      last_cycle;
                logic      requires_flush;
                logic      xreg;
        } elem_ctrl_t;

        typedef struct packed {
                logic       res_valid;
                elem_data_t data;
                elem_mask_t mask;
        } elem_res_t;

        // Fields of the instruction whose destination is being flushed
        typedef struct packed {
                logic      active;
                instr_id_t id;
                vsew_e     eew;
                emul_e     emul;
                vaddr_t    vaddr;
        } flush_state_t;

        // One write towards the vector register file
        typedef struct packed {
                instr_id_t  instr_id;
                vsew_e      eew;
                vaddr_t     vaddr;
                logic       store;
                logic       valid;
                logic       shift;
                logic       elemwise;
                elem_data_t data;
                elem_mask_t mask;
        } vreg_wr_t;

endpackage

// File: common/elem_cfg_pkg.sv
// ================================================
// Element write-back configuration: sizes, widths
// and the element width and grouping encodings
// ================================================

package elem_cfg_pkg;

        // Vector register and assembled result word sizes in bytes
        localparam int unsigned VREG_BYTES = 16;
        localparam int unsigned RES_BYTES  = 8;

        localparam int unsigned ID_W    = 3;
        localparam int unsigned ID_CNT  = 2 ** ID_W;
        localparam int unsigned VADDR_W = 5;

        // Byte count split: byte within register, register within group
        localparam int unsigned CNT_LOW_W = $clog2(VREG_BYTES);
        localparam int unsigned CNT_MUL_W = 3;
        localparam int unsigned RES_OFF_W = $clog2(RES_BYTES);

        typedef logic [ID_W-1:0]                instr_id_t;
        typedef logic [VADDR_W-1:0]             vaddr_t;
        typedef logic [31:0]                    elem_data_t;
        typedef logic [3:0]                     elem_mask_t;
        typedef logic [CNT_MUL_W+CNT_LOW_W-1:0] vd_count_t;

        typedef enum logic [1:0] {
                VSEW_8  = 2'b00,
                VSEW_16 = 2'b01,
                VSEW_32 = 2'b10
        } vsew_e;

        typedef enum logic [1:0] {
                EMUL_1 = 2'b00,
                EMUL_2 = 2'b01,
                EMUL_4 = 2'b10,
                EMUL_8 = 2'b11
        } emul_e;

endpackage
